// File: hdl/ex_pkg.sv
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  op_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  size_t;

    // alu group
    localparam op_t OP_ADD   = 5'd0;
    localparam op_t OP_SUB   = 5'd1;
    localparam op_t OP_SLT   = 5'd2;
    localparam op_t OP_SLTU  = 5'd3;
    localparam op_t OP_AND   = 5'd4;
    localparam op_t OP_OR    = 5'd5;
    localparam op_t OP_XOR   = 5'd6;
    localparam op_t OP_SLL   = 5'd7;
    localparam op_t OP_SRL   = 5'd8;
    localparam op_t OP_SRA   = 5'd9;
    localparam op_t OP_LUI   = 5'd10;

    // divider group
    localparam op_t OP_DIV   = 5'd11;
    localparam op_t OP_DIVU  = 5'd12;
    localparam op_t OP_MOD   = 5'd13;
    localparam op_t OP_MODU  = 5'd14;

    // loads, then stores
    localparam op_t OP_LD_B  = 5'd15;
    localparam op_t OP_LD_BU = 5'd16;
    localparam op_t OP_LD_H  = 5'd17;
    localparam op_t OP_LD_HU = 5'd18;
    localparam op_t OP_LD_W  = 5'd19;
    localparam op_t OP_ST_B  = 5'd20;
    localparam op_t OP_ST_H  = 5'd21;
    localparam op_t OP_ST_W  = 5'd22;

    // start of divide to done, in cycles
    localparam int DIV_CYCLES = 33;

    function automatic logic is_div_op(op_t op);
        return (op >= OP_DIV) && (op <= OP_MODU);
    endfunction

    function automatic logic is_load_op(op_t op);
        return (op >= OP_LD_B) && (op <= OP_LD_W);
    endfunction

    function automatic logic is_store_op(op_t op);
        return (op >= OP_ST_B) && (op <= OP_ST_W);
    endfunction

endpackage

// File: hdl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::op_t   op,
    input  ex_pkg::word_t src1,
    input  ex_pkg::word_t src2,
    output ex_pkg::word_t result
);
    import ex_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    word_t      sra_res;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src2[4:0];

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    assign sra_res = word_t'($signed(src1) >>> shamt);

    always_comb begin
        case (op)
            OP_ADD: begin
                result = sum;
            end
            OP_SUB: begin
                result = diff;
            end
            OP_SLT: begin
                result = {31'd0, lt_signed};
            end
            OP_SLTU: begin
                result = {31'd0, lt_unsigned};
            end
            OP_AND: begin
                result = src1 & src2;
            end
            OP_OR: begin
                result = src1 | src2;
            end
            OP_XOR: begin
                result = src1 ^ src2;
            end
            OP_SLL: begin
                result = src1 << shamt;
            end
            OP_SRL: begin
                result = src1 >> shamt;
            end
            OP_SRA: begin
                result = sra_res;
            end
            OP_LUI: begin
                // decode already placed the immediate in the upper bits
                result = src2;
            end
            default: begin
                // loads and stores take base plus offset as the address
                result = sum;
            end
        endcase
    end

endmodule

// File: hdl/ex_divider.sv
`timescale 1ns/1ps

module ex_divider (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  ex_pkg::op_t   op,
    input  ex_pkg::word_t dividend,
    input  ex_pkg::word_t divisor,
    input  logic          clear,
    output ex_pkg::word_t quotient_or_rem,
    output logic          done
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

    // one cycle to load, then one step per cycle
    localparam logic [4:0] LAST_STEP = 5'(DIV_CYCLES - 2);

    div_state_t  state;
    logic [4:0]  step_cnt;
    word_t       quo;
    word_t       rem;
    word_t       dvs;
    logic        neg_quo;
    logic        neg_rem;
    logic        want_rem;
    logic        op_signed;
    word_t       dividend_mag;
    word_t       divisor_mag;
    logic [32:0] rem_shift;
    logic [32:0] trial;
    word_t       quo_fixed;
    word_t       rem_fixed;

    assign op_signed    = (op == OP_DIV) || (op == OP_MOD);
    assign dividend_mag = (op_signed && dividend[31]) ? -dividend : dividend;
    assign divisor_mag  = (op_signed && divisor[31]) ? -divisor : divisor;

    assign rem_shift = {rem, quo[31]};
    assign trial     = rem_shift - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state    <= DIV_BUSY;
                        step_cnt <= '0;
                    end
                end
                DIV_BUSY: begin
                    step_cnt <= step_cnt + 5'd1;
                    if (step_cnt == LAST_STEP) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (clear) begin
                        state <= DIV_IDLE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DIV_IDLE) && start) begin
            quo      <= dividend_mag;
            rem      <= '0;
            dvs      <= divisor_mag;
            // a zero divisor keeps the all-ones quotient unsigned
            neg_quo  <= op_signed && (dividend[31] ^ divisor[31]) && (divisor != '0);
            neg_rem  <= op_signed && dividend[31];
            want_rem <= (op == OP_MOD) || (op == OP_MODU);
        end else if (state == DIV_BUSY) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= rem_shift[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    assign quo_fixed = neg_quo ? -quo : quo;
    assign rem_fixed = neg_rem ? -rem : rem;

    assign quotient_or_rem = want_rem ? rem_fixed : quo_fixed;
    assign done            = (state == DIV_DONE);

endmodule

// File: hdl/ex_commit.sv
`timescale 1ns/1ps

module ex_commit (
    input  logic          clk,
    input  logic          reset,
    input  logic          valid,
    input  ex_pkg::op_t   op,
    input  ex_pkg::word_t alu_result,
    input  ex_pkg::word_t div_result,
    input  logic          div_done,
    input  ex_pkg::word_t store_data,
    input  logic          mem_allow_in,
    input  logic          data_sram_addr_ok,
    output logic          data_sram_req,
    output logic          data_sram_wr,
    output ex_pkg::size_t data_sram_size,
    output ex_pkg::word_t data_sram_addr,
    output ex_pkg::strb_t data_sram_wstrb,
    output ex_pkg::word_t data_sram_wdata,
    output ex_pkg::word_t result,
    output logic          ale,
    output logic          leave,
    output logic          allow_in
);
    import ex_pkg::*;

    logic  div_op;
    logic  mem_op;
    logic  misaligned;
    logic  accepted;
    logic  ready_go;
    word_t addr;

    assign div_op = is_div_op(op);
    assign mem_op = is_load_op(op) || is_store_op(op);
    assign addr   = alu_result;

    always_comb begin
        case (op)
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                data_sram_size = 2'd1;
            end
            OP_LD_W, OP_ST_W: begin
                data_sram_size = 2'd2;
            end
            default: begin
                data_sram_size = 2'd0;
            end
        endcase
    end

    assign misaligned = ((data_sram_size == 2'd1) && addr[0])
                     || ((data_sram_size == 2'd2) && (addr[1:0] != 2'b00));
    assign ale = valid && mem_op && misaligned;

    // strobe and lane replication
    always_comb begin
        data_sram_wstrb = '0;
        data_sram_wdata = store_data;
        case (op)
            OP_ST_B: begin
                data_sram_wstrb = strb_t'(4'b0001 << addr[1:0]);
                data_sram_wdata = {4{store_data[7:0]}};
            end
            OP_ST_H: begin
                data_sram_wstrb = addr[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{store_data[15:0]}};
            end
            OP_ST_W: begin
                data_sram_wstrb = 4'b1111;
            end
            default: begin
                data_sram_wstrb = '0;
            end
        endcase
    end

    assign data_sram_wr   = is_store_op(op);
    assign data_sram_addr = addr;
    assign data_sram_req  = valid && mem_op && mem_allow_in && !misaligned && !accepted;

    // set on address handshake, dropped when the op moves on
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted <= 1'b0;
        end else if (leave) begin
            accepted <= 1'b0;
        end else if (data_sram_req && data_sram_addr_ok) begin
            accepted <= 1'b1;
        end
    end

    always_comb begin
        if (div_op) begin
            ready_go = div_done;
        end else if (mem_op && !misaligned) begin
            ready_go = accepted || (data_sram_req && data_sram_addr_ok);
        end else begin
            ready_go = 1'b1;
        end
    end

    assign result   = div_op ? div_result : alu_result;
    assign leave    = valid && ready_go && mem_allow_in;
    assign allow_in = !valid || leave;

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  ex_pkg::op_t      in_op,
    input  ex_pkg::word_t    in_src1,
    input  ex_pkg::word_t    in_src2,
    input  ex_pkg::word_t    in_store_data,
    input  ex_pkg::reg_idx_t in_rd,
    input  logic             in_rf_we,
    output logic             allow_in,
    input  logic             mem_allow_in,
    output logic             out_valid,
    output ex_pkg::word_t    out_result,
    output ex_pkg::reg_idx_t out_rd,
    output logic             out_rf_we,
    output ex_pkg::op_t      out_op,
    output logic             out_ale,
    output logic             data_sram_req,
    output logic             data_sram_wr,
    output ex_pkg::size_t    data_sram_size,
    output ex_pkg::word_t    data_sram_addr,
    output ex_pkg::strb_t    data_sram_wstrb,
    output ex_pkg::word_t    data_sram_wdata,
    input  logic             data_sram_addr_ok
);
    import ex_pkg::*;

    logic     stage_valid;
    op_t      held_op;
    word_t    held_src1;
    word_t    held_src2;
    word_t    held_store_data;
    reg_idx_t held_rd;
    logic     held_rf_we;
    word_t    alu_result;
    word_t    div_result;
    logic     div_done;
    logic     leave;
    logic     accept;

    assign accept = in_valid && allow_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (leave) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_op         <= in_op;
            held_src1       <= in_src1;
            held_src2       <= in_src2;
            held_store_data <= in_store_data;
            held_rd         <= in_rd;
            held_rf_we      <= in_rf_we;
        end
    end

    ex_alu alu_i (
        .op     (held_op),
        .src1   (held_src1),
        .src2   (held_src2),
        .result (alu_result)
    );

    // divider only looks at start while idle
    ex_divider divider_i (
        .clk             (clk),
        .reset           (reset),
        .start           (stage_valid && is_div_op(held_op)),
        .op              (held_op),
        .dividend        (held_src1),
        .divisor         (held_src2),
        .clear           (leave),
        .quotient_or_rem (div_result),
        .done            (div_done)
    );

    ex_commit commit_i (
        .clk               (clk),
        .reset             (reset),
        .valid             (stage_valid),
        .op                (held_op),
        .alu_result        (alu_result),
        .div_result        (div_result),
        .div_done          (div_done),
        .store_data        (held_store_data),
        .mem_allow_in      (mem_allow_in),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_wdata   (data_sram_wdata),
        .result            (out_result),
        .ale               (out_ale),
        .leave             (leave),
        .allow_in          (allow_in)
    );

    assign out_valid = stage_valid;
    assign out_rd    = held_rd;
    assign out_rf_we = held_rf_we;
    assign out_op    = held_op;

endmodule

// File: dv/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;
    import ex_pkg::*;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 200;

    typedef struct packed {
        op_t      op;
        word_t    src1;
        word_t    src2;
        word_t    sdata;
        reg_idx_t rd;
        logic     we;
        word_t    result;
        logic     ale;
        size_t    size;
        strb_t    strb;
        word_t    wdata;
    } entry_t;

    logic     clk;
    logic     reset;
    logic     in_valid;
    op_t      in_op;
    word_t    in_src1;
    word_t    in_src2;
    word_t    in_store_data;
    reg_idx_t in_rd;
    logic     in_rf_we;
    logic     allow_in;
    logic     mem_allow_in;
    logic     out_valid;
    word_t    out_result;
    reg_idx_t out_rd;
    logic     out_rf_we;
    op_t      out_op;
    logic     out_ale;
    logic     data_sram_req;
    logic     data_sram_wr;
    size_t    data_sram_size;
    word_t    data_sram_addr;
    strb_t    data_sram_wstrb;
    word_t    data_sram_wdata;
    logic     data_sram_addr_ok;

    entry_t      stim_q[$];
    int          out_idx = 0;
    int          held_cycles = 0;
    int          reqs_seen = 0;
    logic [31:0] lfsr_state = 32'hbd02cff1;
    logic        ok_next = 1'b0;
    logic        allow_next = 1'b1;

    ex_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_strb(input string name, input strb_t exp, input strb_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input size_t exp, input size_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input op_t exp, input op_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [3:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic is_divide(input op_t op);
        return (op >= OP_DIV) && (op <= OP_MODU);
    endfunction

    function automatic logic is_mem_access(input op_t op);
        return (op >= OP_LD_B) && (op <= OP_ST_W);
    endfunction

    function automatic logic is_store_access(input op_t op);
        return (op >= OP_ST_B) && (op <= OP_ST_W);
    endfunction

    task automatic add_calc(input op_t op, input word_t src1, input word_t src2,
                            input reg_idx_t rd, input word_t result);
        stim_q.push_back('{op, src1, src2, '0, rd, 1'b1, result, 1'b0, '0, '0, '0});
    endtask

    task automatic add_mem(input op_t op, input word_t src1, input word_t src2,
                           input word_t sdata, input reg_idx_t rd, input logic we,
                           input word_t addr, input logic ale, input size_t size,
                           input strb_t strb, input word_t wdata);
        stim_q.push_back('{op, src1, src2, sdata, rd, we, addr, ale, size, strb, wdata});
    endtask

    task automatic build_table();
        add_calc(OP_ADD,  32'h00000005, 32'h00000007, 5'd1,  32'h0000000c);
        add_calc(OP_ADD,  32'hffffffff, 32'h00000001, 5'd2,  32'h00000000);
        add_calc(OP_SUB,  32'h00000003, 32'h00000005, 5'd3,  32'hfffffffe);
        add_calc(OP_SLT,  32'hfffffff0, 32'h00000001, 5'd4,  32'h00000001);
        add_calc(OP_SLTU, 32'hfffffff0, 32'h00000001, 5'd5,  32'h00000000);
        add_calc(OP_AND,  32'hf0f01234, 32'h0ff0ffff, 5'd6,  32'h00f01234);
        add_calc(OP_OR,   32'hf000000f, 32'h0f0000f0, 5'd7,  32'hff0000ff);
        add_calc(OP_XOR,  32'haaaa5555, 32'hffff0000, 5'd8,  32'h55555555);
        add_calc(OP_SLL,  32'h00000001, 32'h0000001f, 5'd9,  32'h80000000);
        add_calc(OP_SLL,  32'h12345678, 32'h00000024, 5'd10, 32'h23456780);
        add_calc(OP_SRL,  32'h80000000, 32'h00000004, 5'd11, 32'h08000000);
        add_calc(OP_SRA,  32'h80000000, 32'h00000004, 5'd12, 32'hf8000000);
        add_calc(OP_LUI,  32'h00000000, 32'h12345000, 5'd13, 32'h12345000);
        add_calc(OP_DIV,  32'h00000064, 32'h00000007, 5'd14, 32'h0000000e);
        add_calc(OP_DIV,  32'hffffff9c, 32'h00000007, 5'd15, 32'hfffffff2);
        add_calc(OP_MOD,  32'hffffff9c, 32'h00000007, 5'd16, 32'hfffffffe);
        add_calc(OP_MOD,  32'h00000064, 32'hfffffff9, 5'd17, 32'h00000002);
        add_calc(OP_DIV,  32'hffffff9c, 32'hfffffff9, 5'd18, 32'h0000000e);
        add_calc(OP_DIVU, 32'hfffffff0, 32'h00000010, 5'd19, 32'h0fffffff);
        add_calc(OP_MODU, 32'hffffffff, 32'h00000010, 5'd20, 32'h0000000f);
        // zero divisor
        add_calc(OP_DIV,  32'h00000064, 32'h00000000, 5'd21, 32'hffffffff);
        add_calc(OP_MOD,  32'hffffff9c, 32'h00000000, 5'd22, 32'hffffff9c);
        add_mem(OP_ST_B, 32'h00001000, 32'h00000003, 32'h112233ab, 5'd0, 1'b0,
                32'h00001003, 1'b0, 2'd0, 4'b1000, 32'habababab);
        add_mem(OP_ST_B, 32'h00001000, 32'h00000001, 32'h0000005a, 5'd0, 1'b0,
                32'h00001001, 1'b0, 2'd0, 4'b0010, 32'h5a5a5a5a);
        add_mem(OP_ST_H, 32'h00001000, 32'h00000002, 32'h5566cdef, 5'd0, 1'b0,
                32'h00001002, 1'b0, 2'd1, 4'b1100, 32'hcdefcdef);
        add_mem(OP_ST_H, 32'h00001000, 32'h00000000, 32'h00001234, 5'd0, 1'b0,
                32'h00001000, 1'b0, 2'd1, 4'b0011, 32'h12341234);
        add_mem(OP_ST_W, 32'h00001000, 32'h00000004, 32'hdeadbeef, 5'd0, 1'b0,
                32'h00001004, 1'b0, 2'd2, 4'b1111, 32'hdeadbeef);
        add_mem(OP_LD_W, 32'h00002000, 32'h00000008, 32'h00000000, 5'd23, 1'b1,
                32'h00002008, 1'b0, 2'd2, 4'b0000, 32'h00000000);
        add_mem(OP_LD_B, 32'h00002000, 32'h00000001, 32'h00000000, 5'd24, 1'b1,
                32'h00002001, 1'b0, 2'd0, 4'b0000, 32'h00000000);
        add_mem(OP_LD_HU, 32'h00002000, 32'h00000006, 32'h00000000, 5'd25, 1'b1,
                32'h00002006, 1'b0, 2'd1, 4'b0000, 32'h00000000);
        add_mem(OP_LD_BU, 32'h00002000, 32'hffffffff, 32'h00000000, 5'd26, 1'b1,
                32'h00001fff, 1'b0, 2'd0, 4'b0000, 32'h00000000);
        // misaligned half and word accesses
        add_mem(OP_LD_H, 32'h00002000, 32'h00000003, 32'h00000000, 5'd27, 1'b1,
                32'h00002003, 1'b1, 2'd1, 4'b0000, 32'h00000000);
        add_mem(OP_ST_W, 32'h00001000, 32'h00000002, 32'h01020304, 5'd0, 1'b0,
                32'h00001002, 1'b1, 2'd2, 4'b1111, 32'h01020304);
        add_mem(OP_ST_H, 32'h00001000, 32'h00000001, 32'h0000abcd, 5'd0, 1'b0,
                32'h00001001, 1'b1, 2'd1, 4'b0000, 32'h00000000);
        add_calc(OP_ADD,  32'h00000100, 32'h00000023, 5'd28, 32'h00000123);
    endtask

    // SRAM accept delay and memory-stage back-pressure from one random source
    always @(negedge clk) begin : env_model
        logic [3:0] bits;
        int         sram_delay;
        logic       sram_armed;
        if (reset) begin
            sram_armed = 1'b0;
            ok_next    = 1'b0;
            allow_next = 1'b1;
        end else begin
            draw_bits(2, bits);
            allow_next = (bits[1:0] != 2'b00);
            if (data_sram_req && data_sram_addr_ok) begin
                sram_armed = 1'b0;
                ok_next    = 1'b0;
            end else if (data_sram_req) begin
                if (!sram_armed) begin
                    draw_bits(2, bits);
                    sram_delay = bits[1:0];
                    sram_armed = 1'b1;
                end
                if (sram_delay == 0) begin
                    ok_next = 1'b1;
                end else begin
                    sram_delay--;
                    ok_next = 1'b0;
                end
            end else begin
                ok_next = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        mem_allow_in      <= allow_next;
        data_sram_addr_ok <= ok_next;
    end

    // a held op leaves exactly when allow_in is high while out_valid
    always @(negedge clk) begin : monitor
        entry_t e;
        logic   mem_op;
        logic   exp_req;
        logic   exp_allow;
        if (reset || !out_valid) begin
            held_cycles = 0;
            reqs_seen   = 0;
        end else if (out_idx >= stim_q.size()) begin
            $display("an instruction is held after every table entry has left");
            abort_run();
        end else begin
            e       = stim_q[out_idx];
            mem_op  = is_mem_access(e.op) && !e.ale;
            exp_req = mem_op && mem_allow_in && (reqs_seen == 0);
            if (is_divide(e.op)) begin
                exp_allow = mem_allow_in && (held_cycles >= DIV_CYCLES);
            end else if (exp_req) begin
                exp_allow = data_sram_addr_ok;
            end else if (mem_op) begin
                exp_allow = mem_allow_in && (reqs_seen > 0);
            end else begin
                exp_allow = mem_allow_in;
            end
            check_flag("data_sram_req", exp_req, data_sram_req);
            check_flag("allow_in", exp_allow, allow_in);
            if (data_sram_req) begin
                check_word("data_sram_addr", e.result, data_sram_addr);
                check_size("data_sram_size", e.size, data_sram_size);
                check_flag("data_sram_wr", is_store_access(e.op), data_sram_wr);
                check_strb("data_sram_wstrb", e.strb, data_sram_wstrb);
                if (is_store_access(e.op)) begin
                    check_word("data_sram_wdata", e.wdata, data_sram_wdata);
                end
                if (data_sram_addr_ok) begin
                    reqs_seen++;
                end
            end
            if (allow_in) begin
                check_op("out_op", e.op, out_op);
                check_word("out_result", e.result, out_result);
                check_idx("out_rd", e.rd, out_rd);
                check_flag("out_rf_we", e.we, out_rf_we);
                check_flag("out_ale", e.ale, out_ale);
                out_idx++;
                held_cycles = 0;
                reqs_seen   = 0;
            end else begin
                held_cycles++;
            end
        end
    end

    initial begin
        int waited;
        reset             = 1'b1;
        in_valid          = 1'b0;
        in_op             = OP_ADD;
        in_src1           = '0;
        in_src2           = '0;
        in_store_data     = '0;
        in_rd             = '0;
        in_rf_we          = 1'b0;
        mem_allow_in      = 1'b1;
        data_sram_addr_ok = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("data_sram_req", 1'b0, data_sram_req);
        check_flag("allow_in", 1'b1, allow_in);

        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk);
            in_valid      <= 1'b1;
            in_op         <= stim_q[i].op;
            in_src1       <= stim_q[i].src1;
            in_src2       <= stim_q[i].src2;
            in_store_data <= stim_q[i].sdata;
            in_rd         <= stim_q[i].rd;
            in_rf_we      <= stim_q[i].we;
            waited = 0;
            @(negedge clk);
            while (!allow_in) begin
                waited++;
                if (waited > ACCEPT_TIMEOUT) begin
                    $display("timeout: table entry %0d was never accepted", i);
                    abort_run();
                end
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        waited = 0;
        while ((out_idx < stim_q.size()) && (waited < DRAIN_TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (out_idx == stim_q.size()) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("timeout: only %0d of %0d instructions left the stage",
                     out_idx, stim_q.size());
            abort_run();
        end
    end

endmodule

// File: flist.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_divider.sv
hdl/ex_commit.sv
hdl/ex_stage.sv
dv/ex_stage_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hdl/ex_pkg.sv
      - hdl/ex_alu.sv
      - hdl/ex_divider.sv
      - hdl/ex_commit.sv
      - hdl/ex_stage.sv
  - target: test
    files:
      - dv/ex_stage_tb.sv
